/* hdl/dec_consts.svh */
// ==============================
// Opcode values and field widths of the decode stage
// The widths must agree with the instruction union in dec_pkg
// ==============================

`ifndef DEC_CONSTS_SVH
`define DEC_CONSTS_SVH

// Field widths of the 32-bit instruction word
`define DEC_OP_W      7
`define DEC_REG_W     5
`define DEC_IMM_W     15
`define DEC_FUNC_W    10

// Implemented opcodes, anything else decodes as unimplemented
`define DEC_OP_NOP    7'h00
`define DEC_OP_LOAD   7'h03
`define DEC_OP_FENCE  7'h0f
`define DEC_OP_ADDI   7'h13
`define DEC_OP_STORE  7'h23
`define DEC_OP_MUL    7'h31
`define DEC_OP_DIV    7'h32
`define DEC_OP_ADD    7'h33
`define DEC_OP_BRANCH 7'h63
`define DEC_OP_CSR    7'h73

// Registers from this number up are reserved for machine mode
`define DEC_PRIV_REG  5'd28

// Low immediate byte that marks a synchronizing fence
`define DEC_SYNC_CODE 8'hff

`endif

/* hdl/dec_pkg.sv */
// ==============================
// Shared types of the decode stage
// Field layout follows the widths in dec_consts.svh
// ==============================

`include "dec_consts.svh"

package dec_pkg;

	// ==============================
	// Instruction word
	// ==============================

	// Register format, used by ADD, MUL and DIV
	// The function field is carried but not decoded by this stage
	typedef struct packed {
		logic [`DEC_FUNC_W-1:0] func;
		logic [`DEC_REG_W-1:0]  rs2;
		logic [`DEC_REG_W-1:0]  rs1;
		logic [`DEC_REG_W-1:0]  rd;
		logic [`DEC_OP_W-1:0]   opcode;
	} instr_r_t;

	// Immediate format, shares opcode, rd and rs1 with the register format
	// The immediate is signed and occupies the top fifteen bits
	typedef struct packed {
		logic [`DEC_IMM_W-1:0] imm;
		logic [`DEC_REG_W-1:0] rs1;
		logic [`DEC_REG_W-1:0] rd;
		logic [`DEC_OP_W-1:0]  opcode;
	} instr_i_t;

	// The same word seen through either format
	// The opcode sits in the same bits of both views, so either may be used to select
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// ==============================
	// Mode and fault cause
	// ==============================

	// User mode may not name the privileged registers
	typedef enum logic {
		mode_user    = 1'b0,
		mode_machine = 1'b1
	} op_mode_e;

	// Fault reported alongside the decode result
	// The stage only reports a cause, a later stage raises the exception
	typedef enum logic [1:0] {
		cause_none   = 2'd0,
		cause_badreg = 2'd1,
		cause_unimp  = 2'd2
	} cause_e;

endpackage

/* hdl/dec_const.sv */
// ==============================
// Immediate extraction, purely combinational
// Only the immediate format carries a constant
// ==============================

`include "dec_consts.svh"

module dec_const (
	input  dec_pkg::instr_u instr,
	output logic [31:0]     imm,
	output logic            has_imm
);

	// Sign-extended copy of the immediate field
	logic [31:0] imm_sext;

	// Replicate the top immediate bit into the upper word
	assign imm_sext = {{(32 - `DEC_IMM_W){instr.i.imm[`DEC_IMM_W-1]}}, instr.i.imm};

	always_comb begin
		imm = 32'd0;
		has_imm = 1'b0;
		case (instr.i.opcode)
			// Every immediate-format opcode passes the constant on
			// FENCE carries it too, its low byte selects the synchronizing form
			`DEC_OP_ADDI,
			`DEC_OP_LOAD,
			`DEC_OP_STORE,
			`DEC_OP_BRANCH,
			`DEC_OP_CSR,
			`DEC_OP_FENCE: begin
				imm = imm_sext;
				has_imm = 1'b1;
			end
			// Register format, NOP and unknown opcodes have no constant
			default: begin
				imm = 32'd0;
				has_imm = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/dec_regs.sv */
// ==============================
// Register specifier decode and privilege check
// Unknown opcodes are read in register format so their specifiers are still checked
// ==============================

`include "dec_consts.svh"

module dec_regs (
	input  dec_pkg::op_mode_e     om,
	input  dec_pkg::instr_u       instr,
	output logic [`DEC_REG_W-1:0] rs1,
	output logic [`DEC_REG_W-1:0] rs2,
	output logic [`DEC_REG_W-1:0] rd,
	output logic                  rs1z,
	output logic                  rs2z,
	output logic                  rdz,
	output logic                  has_rs2,
	output logic                  badreg
);

	// Which specifiers the opcode names
	logic use_rs1;
	logic use_rs2;
	logic use_rd;
	// Second source taken from the rd field, as for STORE and BRANCH
	logic rs2_from_rd;

	always_comb begin
		use_rs1 = 1'b1;
		use_rs2 = 1'b1;
		use_rd = 1'b1;
		rs2_from_rd = 1'b0;
		case (instr.r.opcode)
			`DEC_OP_ADD, `DEC_OP_MUL, `DEC_OP_DIV: begin
				use_rs2 = 1'b1;
			end
			// Immediate forms write rd from rs1 and the constant
			`DEC_OP_ADDI, `DEC_OP_LOAD, `DEC_OP_CSR: begin
				use_rs2 = 1'b0;
			end
			// No destination, the rd field holds the second source
			`DEC_OP_STORE, `DEC_OP_BRANCH: begin
				use_rd = 1'b0;
				rs2_from_rd = 1'b1;
			end
			`DEC_OP_FENCE, `DEC_OP_NOP: begin
				use_rs1 = 1'b0;
				use_rs2 = 1'b0;
				use_rd = 1'b0;
			end
			// Unknown opcodes keep all three register-format specifiers
			default: begin
				use_rd = 1'b1;
			end
		endcase
	end

	// Unused specifiers read as register zero
	assign rs1 = use_rs1 ? instr.r.rs1 : '0;
	assign rs2 = !use_rs2 ? '0 : (rs2_from_rd ? instr.i.rd : instr.r.rs2);
	assign rd = use_rd ? instr.r.rd : '0;

	// A zero flag marks a specifier the instruction does not name
	assign rs1z = !use_rs1;
	assign rs2z = !use_rs2;
	assign rdz = !use_rd;
	assign has_rs2 = use_rs2;

	// Unused specifiers are zero, so only named registers can trip the check
	assign badreg = (om == dec_pkg::mode_user) &&
		(rs1 >= `DEC_PRIV_REG || rs2 >= `DEC_PRIV_REG || rd >= `DEC_PRIV_REG);

endmodule

/* hdl/dec_class.sv */
// ==============================
// Opcode classification into functional-unit flags
// At most one unit group is active, an unknown opcode sets only unimp
// ==============================

`include "dec_consts.svh"

module dec_class (
	input  dec_pkg::instr_u instr,
	output logic            nop,
	output logic            alu,
	output logic            mul,
	output logic            div,
	output logic            load,
	output logic            store,
	output logic            branch,
	output logic            fence,
	output logic            csr,
	output logic            sync,
	output logic            unimp
);

	always_comb begin
		nop = 1'b0;
		alu = 1'b0;
		mul = 1'b0;
		div = 1'b0;
		load = 1'b0;
		store = 1'b0;
		branch = 1'b0;
		fence = 1'b0;
		csr = 1'b0;
		sync = 1'b0;
		unimp = 1'b0;
		case (instr.r.opcode)
			`DEC_OP_ADD, `DEC_OP_ADDI: begin
				alu = 1'b1;
			end
			`DEC_OP_MUL: begin
				mul = 1'b1;
			end
			`DEC_OP_DIV: begin
				div = 1'b1;
			end
			`DEC_OP_LOAD: begin
				load = 1'b1;
			end
			`DEC_OP_STORE: begin
				store = 1'b1;
			end
			// Branch compare and CSR read-modify run through the ALU as well
			`DEC_OP_BRANCH: begin
				alu = 1'b1;
				branch = 1'b1;
			end
			`DEC_OP_CSR: begin
				alu = 1'b1;
				csr = 1'b1;
			end
			// A fence whose low immediate byte is all ones also synchronizes
			`DEC_OP_FENCE: begin
				fence = 1'b1;
				sync = (instr.i.imm[7:0] == `DEC_SYNC_CODE);
			end
			`DEC_OP_NOP: begin
				nop = 1'b1;
			end
			default: begin
				unimp = 1'b1;
			end
		endcase
	end

endmodule

/* hdl/dec_stage.sv */
// ==============================
// Decode stage top level, one cycle from an enabled edge to the outputs
// Outputs hold while en is low; there is no other back-pressure
// Reset and an invalid word both register a bubble
// ==============================

module dec_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic              en,
	input  logic              instr_valid,
	input  dec_pkg::op_mode_e om,
	input  dec_pkg::instr_u   instr,
	output logic              valid,
	output logic              nop,
	output logic              alu,
	output logic              mul,
	output logic              div,
	output logic              load,
	output logic              store,
	output logic              mem,
	output logic              branch,
	output logic              fence,
	output logic              sync,
	output logic              csr,
	output logic [4:0]        rs1,
	output logic [4:0]        rs2,
	output logic [4:0]        rd,
	output logic              rs1z,
	output logic              rs2z,
	output logic              rdz,
	output logic              has_rs2,
	output logic              has_imm,
	output logic [31:0]       imm,
	output dec_pkg::cause_e   cause
);

	// Combinational decode results
	logic d_nop, d_alu, d_mul, d_div, d_load, d_store;
	logic d_branch, d_fence, d_csr, d_sync, d_unimp;
	logic [4:0] d_rs1, d_rs2, d_rd;
	logic d_rs1z, d_rs2z, d_rdz, d_has_rs2, d_badreg;
	logic [31:0] d_imm;
	logic d_has_imm;
	dec_pkg::cause_e d_cause;

	// ==============================
	// Decoders
	// ==============================

	dec_const i_dec_const (
		.instr   (instr),
		.imm     (d_imm),
		.has_imm (d_has_imm)
	);

	dec_regs i_dec_regs (
		.om      (om),
		.instr   (instr),
		.rs1     (d_rs1),
		.rs2     (d_rs2),
		.rd      (d_rd),
		.rs1z    (d_rs1z),
		.rs2z    (d_rs2z),
		.rdz     (d_rdz),
		.has_rs2 (d_has_rs2),
		.badreg  (d_badreg)
	);

	dec_class i_dec_class (
		.instr  (instr),
		.nop    (d_nop),
		.alu    (d_alu),
		.mul    (d_mul),
		.div    (d_div),
		.load   (d_load),
		.store  (d_store),
		.branch (d_branch),
		.fence  (d_fence),
		.csr    (d_csr),
		.sync   (d_sync),
		.unimp  (d_unimp)
	);

	// Unimplemented outranks a bad register
	assign d_cause = d_unimp ? dec_pkg::cause_unimp :
		(d_badreg ? dec_pkg::cause_badreg : dec_pkg::cause_none);

	// ==============================
	// Output register
	// ==============================

	always_ff @(posedge clk) begin
		if (rst || (en && !instr_valid)) begin
			// Bubble: a NOP with no destination and no fault
			valid <= 1'b0;
			{nop, alu, mul, div, load, store, mem} <= 7'b1000000;
			{branch, fence, sync, csr} <= 4'b0000;
			{rs1, rs2, rd} <= 15'd0;
			{rs1z, rs2z, rdz, has_rs2} <= 4'b0010;
			has_imm <= 1'b0;
			imm <= 32'd0;
			cause <= dec_pkg::cause_none;
		end else if (en) begin
			valid <= 1'b1;
			// An unknown opcode travels on as a NOP carrying its cause
			nop <= d_nop | d_unimp;
			{alu, mul, div, load, store} <= {d_alu, d_mul, d_div, d_load, d_store};
			mem <= d_load | d_store;
			{branch, fence, sync, csr} <= {d_branch, d_fence, d_sync, d_csr};
			{rs1, rs2, rd} <= {d_rs1, d_rs2, d_rd};
			{rs1z, rs2z, rdz, has_rs2} <= {d_rs1z, d_rs2z, d_rdz, d_has_rs2};
			has_imm <= d_has_imm;
			imm <= d_imm;
			cause <= d_cause;
		end
	end

endmodule

/* testbench/dec_stage_sva.sv */
// ==============================
// Output assertions of the decode stage bound into every dec_stage
// Checks are off while rst is high
// ==============================

module dec_stage_sva (
	input logic            clk,
	input logic            rst,
	input logic            en,
	input logic            valid,
	input logic            nop,
	input logic            alu,
	input logic            mul,
	input logic            div,
	input logic            load,
	input logic            store,
	input logic            mem,
	input logic            branch,
	input logic            fence,
	input logic            sync,
	input logic            csr,
	input logic [4:0]      rs1,
	input logic [4:0]      rs2,
	input logic [4:0]      rd,
	input logic            rs1z,
	input logic            rs2z,
	input logic            rdz,
	input logic            has_rs2,
	input logic            has_imm,
	input logic [31:0]     imm,
	input dec_pkg::cause_e cause
);

	timeunit 1ns;
	timeprecision 1ps;

	// Memory flag is only a summary of load and store
	mem_is_load_or_store: assert property (@(posedge clk) disable iff (rst)
		mem == (load | store))
		else $error("mem differs from load or store");

	// A cycle with en low must leave the register untouched
	hold_when_disabled: assert property (@(posedge clk) disable iff (rst)
		!en |=> $stable({valid, nop, alu, mul, div, load, store, mem, branch, fence, sync,
			csr, rs1, rs2, rd, rs1z, rs2z, rdz, has_rs2, has_imm, imm, cause}))
		else $error("outputs changed after a cycle with en low");

	// A NOP, bubble or unknown opcode drives no functional unit
	nop_has_no_unit: assert property (@(posedge clk) disable iff (rst)
		nop |-> !(alu | mul | div | load | store | mem | branch | fence | sync | csr))
		else $error("nop set together with a unit flag");

endmodule

bind dec_stage dec_stage_sva i_dec_stage_sva (.*);

/* testbench/dec_stage_tb.sv */
// ==============================
// Directed testbench of the decode stage with one instruction per enabled edge
// Expected values come from a reference model of the decode rules
// Stops at the first mismatch
// ==============================

`include "dec_consts.svh"

module dec_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Edges to wait for the enabled edge before giving up
	localparam int wait_limit = 20;

	logic clk;
	logic rst;
	logic en;
	logic instr_valid;
	dec_pkg::op_mode_e om;
	dec_pkg::instr_u instr;
	logic valid, nop, alu, mul, div, load, store, mem, branch, fence, sync, csr;
	logic [4:0] rs1, rs2, rd;
	logic rs1z, rs2z, rdz, has_rs2, has_imm;
	logic [31:0] imm;
	dec_pkg::cause_e cause;

	// Expected outputs as filled in by the reference model
	logic exp_valid, exp_nop, exp_alu, exp_mul, exp_div, exp_load, exp_store;
	logic exp_mem, exp_branch, exp_fence, exp_sync, exp_csr;
	logic [4:0] exp_rs1, exp_rs2, exp_rd;
	logic exp_rs1z, exp_rs2z, exp_rdz, exp_has_rs2, exp_has_imm;
	logic [31:0] exp_imm;
	logic [1:0] exp_cause;
	int errors;

	dec_stage i_dec_stage (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// Reference model and checks
	// ==============================

	// Decodes a word from the raw bit positions of the instruction format
	function automatic void predict(input logic v, input dec_pkg::op_mode_e m,
		input logic [31:0] w);
		logic [6:0] op;
		logic [14:0] f_imm;
		logic known, use1, use2, used, s2rd, imm_op;
		op = w[6:0];
		f_imm = w[31:17];
		{exp_nop, exp_alu, exp_mul, exp_div, exp_load, exp_store} = 6'b0;
		{exp_mem, exp_branch, exp_fence, exp_sync, exp_csr} = 5'b0;
		{known, use1, use2, used, s2rd, imm_op} = 6'b111100;
		case (op)
			`DEC_OP_ADD: exp_alu = 1'b1;
			`DEC_OP_MUL: exp_mul = 1'b1;
			`DEC_OP_DIV: exp_div = 1'b1;
			`DEC_OP_ADDI, `DEC_OP_LOAD, `DEC_OP_CSR: begin
				exp_alu = (op != `DEC_OP_LOAD);
				exp_load = (op == `DEC_OP_LOAD);
				exp_csr = (op == `DEC_OP_CSR);
				{use2, imm_op} = 2'b01;
			end
			// Stores and branches read the rd field as a second source
			`DEC_OP_STORE, `DEC_OP_BRANCH: begin
				exp_store = (op == `DEC_OP_STORE);
				exp_alu = (op == `DEC_OP_BRANCH);
				exp_branch = (op == `DEC_OP_BRANCH);
				{used, s2rd, imm_op} = 3'b011;
			end
			`DEC_OP_FENCE: begin
				exp_fence = 1'b1;
				exp_sync = (f_imm[7:0] == `DEC_SYNC_CODE);
				{use1, use2, used, imm_op} = 4'b0001;
			end
			`DEC_OP_NOP: begin
				exp_nop = 1'b1;
				{use1, use2, used} = 3'b000;
			end
			// Unknown words travel as a NOP but keep all three specifiers
			default: {known, exp_nop} = 2'b01;
		endcase
		exp_mem = exp_load | exp_store;
		exp_rs1 = use1 ? w[16:12] : 5'd0;
		exp_rs2 = !use2 ? 5'd0 : (s2rd ? w[11:7] : w[21:17]);
		exp_rd = used ? w[11:7] : 5'd0;
		{exp_rs1z, exp_rs2z, exp_rdz, exp_has_rs2} = {!use1, !use2, !used, use2};
		exp_has_imm = imm_op;
		exp_imm = imm_op ? {{17{f_imm[14]}}, f_imm} : 32'd0;
		if (!known)
			exp_cause = dec_pkg::cause_unimp;
		else if (m == dec_pkg::mode_user && (exp_rs1 >= 28 || exp_rs2 >= 28 || exp_rd >= 28))
			exp_cause = dec_pkg::cause_badreg;
		else
			exp_cause = dec_pkg::cause_none;
		exp_valid = 1'b1;
		if (!v) begin
			// Bubble
			{exp_valid, exp_nop, exp_alu, exp_mul, exp_div, exp_load, exp_store} = 7'b0100000;
			{exp_mem, exp_branch, exp_fence, exp_sync, exp_csr} = 5'b0;
			{exp_rs1, exp_rs2, exp_rd, exp_imm} = 47'd0;
			{exp_rs1z, exp_rs2z, exp_rdz, exp_has_rs2, exp_has_imm} = 5'b00100;
			exp_cause = dec_pkg::cause_none;
		end
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "Decode output does not match the reference model");
		end
	endtask

	task automatic compare_outputs(input string tag);
		check({tag, " valid"}, valid, exp_valid);
		check({tag, " flags"}, {nop, alu, mul, div, load, store, mem, branch, fence, sync, csr},
			{exp_nop, exp_alu, exp_mul, exp_div, exp_load, exp_store, exp_mem, exp_branch,
			exp_fence, exp_sync, exp_csr});
		check({tag, " rs1"}, rs1, exp_rs1);
		check({tag, " rs2"}, rs2, exp_rs2);
		check({tag, " rd"}, rd, exp_rd);
		check({tag, " zero flags"}, {rs1z, rs2z, rdz, has_rs2},
			{exp_rs1z, exp_rs2z, exp_rdz, exp_has_rs2});
		check({tag, " has_imm"}, has_imm, exp_has_imm);
		check({tag, " imm"}, imm, exp_imm);
		check({tag, " cause"}, cause, exp_cause);
	endtask

	// Presents one word for one enabled edge and checks the result at the falling edge
	task automatic issue(input string tag, input logic v, input dec_pkg::op_mode_e m,
		input logic [31:0] w);
		int cycles;
		@(posedge clk);
		en <= 1'b1;
		instr_valid <= v;
		om <= m;
		instr <= w;
		predict(v, m, w);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!en && cycles < wait_limit);
		if (!en) begin
			$display("Timed out waiting for the enabled clock edge");
			$display("sim failed");
			$fatal(1, "No enabled edge seen");
		end
		en <= 1'b0;
		@(negedge clk);
		compare_outputs(tag);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset();
		@(negedge clk);
		predict(1'b0, dec_pkg::mode_machine, 32'd0);
		compare_outputs("reset");
	endtask

	task automatic test_reg_ops();
		logic [6:0] ops [3];
		logic [31:0] w;
		ops = '{`DEC_OP_ADD, `DEC_OP_MUL, `DEC_OP_DIV};
		for (int i = 0; i < 24; i++) begin
			w = $urandom();
			w[6:0] = ops[i % 3];
			issue("reg op", 1'b1, dec_pkg::mode_machine, w);
		end
	endtask

	task automatic test_imm_ops();
		logic [6:0] ops [6];
		logic [31:0] w;
		ops = '{`DEC_OP_ADDI, `DEC_OP_LOAD, `DEC_OP_CSR, `DEC_OP_STORE, `DEC_OP_BRANCH,
			`DEC_OP_FENCE};
		for (int i = 0; i < 30; i++) begin
			w = $urandom();
			w[6:0] = ops[i % 6];
			issue("imm op", 1'b1, dec_pkg::mode_machine, w);
		end
		// Most negative immediate on an ADDI
		issue("addi neg", 1'b1, dec_pkg::mode_machine, {15'h4000, 5'd3, 5'd4, `DEC_OP_ADDI});
		check("addi neg imm", imm, 32'hffff_c000);
		// A store names its data register in the rd field
		issue("store", 1'b1, dec_pkg::mode_machine, {15'h0010, 5'd7, 5'd9, `DEC_OP_STORE});
		check("store rs2", {rs2, rdz}, {5'd9, 1'b1});
		issue("sync fence", 1'b1, dec_pkg::mode_machine, {15'h00ff, 10'd0, `DEC_OP_FENCE});
		check("sync fence sync", sync, 1'b1);
		issue("plain fence", 1'b1, dec_pkg::mode_machine, {15'h00fe, 10'd0, `DEC_OP_FENCE});
		check("plain fence sync", sync, 1'b0);
	endtask

	task automatic test_user_mode();
		logic [31:0] w;
		issue("user add", 1'b1, dec_pkg::mode_user, {10'd0, 5'd1, 5'd28, 5'd2, `DEC_OP_ADD});
		check("user add cause", cause, dec_pkg::cause_badreg);
		issue("user addi", 1'b1, dec_pkg::mode_user, {15'd5, 5'd3, 5'd31, `DEC_OP_ADDI});
		check("user addi cause", cause, dec_pkg::cause_badreg);
		issue("user low", 1'b1, dec_pkg::mode_user, {10'd0, 5'd27, 5'd27, 5'd27, `DEC_OP_ADD});
		check("user low cause", cause, dec_pkg::cause_none);
		// Unknown opcode outranks the privileged register
		issue("user unimp", 1'b1, dec_pkg::mode_user, {10'd0, 5'd1, 5'd30, 5'd2, 7'h7f});
		check("user unimp", {cause, nop}, {dec_pkg::cause_unimp, 1'b1});
		for (int i = 0; i < 20; i++) begin
			w = $urandom();
			issue("user random", 1'b1, dec_pkg::mode_user, w);
		end
	endtask

	task automatic test_hold_and_bubble();
		logic [31:0] w;
		w = $urandom();
		w[6:0] = `DEC_OP_ADD;
		issue("hold setup", 1'b1, dec_pkg::mode_machine, w);
		// The expected values stay those of the last enabled edge
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			en <= 1'b0;
			instr_valid <= 1'($urandom_range(0, 1));
			om <= dec_pkg::op_mode_e'($urandom_range(0, 1));
			instr <= $urandom();
			@(negedge clk);
			compare_outputs("hold");
		end
		issue("bubble", 1'b0, dec_pkg::mode_machine, w);
		check("bubble valid nop rdz", {valid, nop, rdz}, 3'b011);
	endtask

	initial begin
		errors = 0;
		void'($urandom(32'h2e67));
		rst <= 1'b1;
		en <= 1'b0;
		instr_valid <= 1'b0;
		om <= dec_pkg::mode_machine;
		instr <= 32'd0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_reg_ops();
		test_imm_ops();
		test_user_mode();
		test_hold_and_bubble();
		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "Checks reported errors");
		end
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/dec_pkg.sv
hdl/dec_const.sv
hdl/dec_regs.sv
hdl/dec_class.sv
hdl/dec_stage.sv
testbench/dec_stage_sva.sv
testbench/dec_stage_tb.sv

/* Bender.yml */
package:
  name: dec_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dec_pkg.sv
      - hdl/dec_const.sv
      - hdl/dec_regs.sv
      - hdl/dec_class.sv
      - hdl/dec_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/dec_stage_sva.sv
      - testbench/dec_stage_tb.sv
